// ==== source/lsu_pkg.sv ====
// LSU package with opcode fields, exception codes, widths, instruction union and bus structs
package lsu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN      = 32;
    localparam int STRB_W    = 4;
    localparam int EXC_W     = 6;
    localparam int TAG_DEPTH = 2;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // Size and signedness in funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // --------------------
    // Exception codes
    // --------------------
    // Bit 4 marks a valid exception and the low bits carry the RISC-V cause
    localparam logic [EXC_W-1:0] EXC_NONE             = 6'h00;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_LOAD  = 6'h14;
    localparam logic [EXC_W-1:0] EXC_FAULT_LOAD       = 6'h15;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_STORE = 6'h16;
    localparam logic [EXC_W-1:0] EXC_FAULT_STORE      = 6'h17;

    // --------------------
    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } insn_s_fmt_t;

    // Same word seen as a load (I-type) or a store (S-type)
    typedef union packed {
        insn_i_fmt_t i_fmt;
        insn_s_fmt_t s_fmt;
    } lsu_insn_u;

    // Pipeline side
    typedef struct packed {
        logic            valid;
        lsu_insn_u       insn;
        logic [XLEN-1:0] ra_operand;
        logic [XLEN-1:0] rb_operand;
    } opcode_t;

    // Bus side
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   data_wr;
        logic              rd;
        logic [STRB_W-1:0] wr;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] data_rd;
        logic            ack;
        logic            error;
    } mem_resp_t;

    // Per-access information kept until completion
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            is_signed;
        logic            half;
        logic            is_byte;
        logic            load;
    } lsu_tag_t;

    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  value;
        logic [EXC_W-1:0] exception;
    } wb_t;

endpackage

// ==== source/lsu_request.sv ====
// LSU request stage with decode, address generation, store lanes, E1 register and stall
module lsu_request
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  lsu_pkg::opcode_t  opcode_i,
    input  logic              mem_accept_i,
    input  lsu_pkg::mem_resp_t mem_resp_i,
    output lsu_pkg::mem_req_t mem_req_o,
    output logic              stall_o,
    output logic              tag_push_o,
    output lsu_pkg::lsu_tag_t tag_o,
    output logic              unaligned_e2_o
);
    import lsu_pkg::*;

    logic [6:0]        opc_w;
    logic [2:0]        f3_w;
    logic              load_w;
    logic              store_w;
    logic              size_byte_w;
    logic              size_half_w;
    logic              size_word_w;
    logic [XLEN-1:0]   imm_i_w;
    logic [XLEN-1:0]   imm_s_w;
    logic [XLEN-1:0]   addr_w;
    logic              unaligned_w;
    logic [XLEN-1:0]   data_r;
    logic [STRB_W-1:0] wr_r;

    // E1 register
    logic              rd_q;
    logic [STRB_W-1:0] wr_q;
    logic              unaligned_e1_q;
    logic [XLEN-1:0]   data_wr_q;
    lsu_tag_t          tag_q;

    logic              unaligned_e2_q;
    logic              pending_q;
    logic              req_active_w;
    logic              issue_w;
    logic              complete_ok_w;
    logic              complete_err_w;
    logic              delay_w;
    logic              wait_accept_w;
    logic              squash_w;

    // --------------------
    // Decode
    // --------------------
    assign opc_w = opcode_i.insn.i_fmt.opcode;
    assign f3_w  = opcode_i.insn.i_fmt.funct3;

    assign load_w  = opcode_i.valid && (opc_w == OPC_LOAD) &&
                     (f3_w inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
    assign store_w = opcode_i.valid && (opc_w == OPC_STORE) &&
                     (f3_w inside {F3_B, F3_H, F3_W});

    assign size_byte_w = (f3_w[1:0] == 2'b00);
    assign size_half_w = (f3_w[1:0] == 2'b01);
    assign size_word_w = (f3_w[1:0] == 2'b10);

    // Immediates of both formats picked by instruction class
    assign imm_i_w = {{20{opcode_i.insn.i_fmt.imm[11]}}, opcode_i.insn.i_fmt.imm};
    assign imm_s_w = {{20{opcode_i.insn.s_fmt.imm_hi[6]}}, opcode_i.insn.s_fmt.imm_hi,
                      opcode_i.insn.s_fmt.imm_lo};
    assign addr_w  = opcode_i.ra_operand + (store_w ? imm_s_w : imm_i_w);

    assign unaligned_w = (load_w || store_w) &&
                         ((size_word_w && (addr_w[1:0] != 2'b00)) ||
                          (size_half_w && addr_w[0]));

    // Store data into its byte lanes
    always_comb
    begin
        data_r = '0;
        wr_r   = '0;
        if (store_w && !unaligned_w)
        begin
            case (f3_w[1:0])
                2'b00:
                begin
                    data_r = {24'b0, opcode_i.rb_operand[7:0]} << {addr_w[1:0], 3'b000};
                    wr_r   = 4'b0001 << addr_w[1:0];
                end
                2'b01:
                begin
                    data_r = {16'b0, opcode_i.rb_operand[15:0]} << {addr_w[1:0], 3'b000};
                    wr_r   = 4'b0011 << addr_w[1:0];
                end
                default:
                begin
                    data_r = opcode_i.rb_operand;
                    wr_r   = 4'b1111;
                end
            endcase
        end
    end

    // --------------------
    // Outstanding access
    // --------------------
    assign req_active_w   = mem_req_o.rd || (|mem_req_o.wr);
    assign issue_w        = req_active_w && mem_accept_i;
    assign complete_ok_w  = mem_resp_i.ack && !mem_resp_i.error;
    assign complete_err_w = mem_resp_i.ack && mem_resp_i.error;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pending_q <= 1'b0;
        else if (issue_w)
            pending_q <= 1'b1;
        else if (mem_resp_i.ack)
            pending_q <= 1'b0;
    end

    // Hold back while the previous response is still due
    assign delay_w       = pending_q && !complete_ok_w;
    assign wait_accept_w = req_active_w && !mem_accept_i;
    // Fault on the previous access kills whatever sits in E1
    assign squash_w      = complete_err_w || unaligned_e2_q;

    // Dummy ack for a misaligned access
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            unaligned_e2_q <= 1'b0;
        else
            unaligned_e2_q <= unaligned_e1_q && !delay_w;
    end

    // --------------------
    // E1 register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q           <= 1'b0;
            wr_q           <= '0;
            unaligned_e1_q <= 1'b0;
        end
        else if (squash_w)
        begin
            rd_q           <= 1'b0;
            wr_q           <= '0;
            unaligned_e1_q <= 1'b0;
        end
        else if (!stall_o)
        begin
            rd_q           <= load_w && !unaligned_w;
            wr_q           <= wr_r;
            unaligned_e1_q <= unaligned_w;
        end
        else if (unaligned_e1_q && !delay_w)
            unaligned_e1_q <= 1'b0;
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_o)
        begin
            data_wr_q       <= data_r;
            tag_q.addr      <= addr_w;
            tag_q.is_signed <= load_w && !f3_w[2];
            tag_q.half      <= size_half_w;
            tag_q.is_byte   <= size_byte_w;
            tag_q.load      <= load_w;
        end
    end

    // Bus request is masked until the earlier access completes
    assign mem_req_o.addr    = {tag_q.addr[XLEN-1:2], 2'b00};
    assign mem_req_o.data_wr = data_wr_q;
    assign mem_req_o.rd      = rd_q && !delay_w;
    assign mem_req_o.wr      = wr_q & ~{STRB_W{delay_w}};

    assign stall_o        = wait_accept_w || delay_w || unaligned_e1_q;
    assign tag_push_o     = issue_w || (unaligned_e1_q && !delay_w);
    assign tag_o          = tag_q;
    assign unaligned_e2_o = unaligned_e2_q;

    // --------------------
    // Assertions
    // --------------------
    a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_req_o.rd && (|mem_req_o.wr)));

    a_ack_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_resp_i.ack |-> pending_q);

endmodule

// ==== source/lsu_resp_fifo.sv ====
// Tag FIFO holding the access information of each issued or dummy-completed access
module lsu_resp_fifo
#(
    parameter int DEPTH = lsu_pkg::TAG_DEPTH
)
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              push_i,
    input  logic              pop_i,
    input  lsu_pkg::lsu_tag_t data_i,
    output lsu_pkg::lsu_tag_t data_o
);
    import lsu_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   cnt_t;

    lsu_tag_t mem_q [DEPTH];
    ptr_t     rd_ptr_q;
    ptr_t     wr_ptr_q;
    cnt_t     count_q;
    logic     full_w;
    logic     empty_w;
    logic     do_push_w;
    logic     do_pop_w;

    assign full_w    = (count_q == cnt_t'(DEPTH));
    assign empty_w   = (count_q == '0);
    assign do_push_w = push_i && !full_w;
    assign do_pop_w  = pop_i && !empty_w;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push_w)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop_w)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (do_push_w && !do_pop_w)
                count_q <= count_q + 1'b1;
            else if (!do_push_w && do_pop_w)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (do_push_w)
            mem_q[wr_ptr_q] <= data_i;
    end

    // Oldest entry
    assign data_o = mem_q[rd_ptr_q];

    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_w);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_w);

endmodule

// ==== source/lsu_response.sv ====
// LSU response stage with load extraction, extension and exception encoding
module lsu_response
(
    input  lsu_pkg::mem_resp_t mem_resp_i,
    input  logic               unaligned_e2_i,
    input  lsu_pkg::lsu_tag_t  tag_i,
    output lsu_pkg::wb_t       wb_o
);
    import lsu_pkg::*;

    logic [7:0]  byte_sel_w;
    logic [15:0] half_sel_w;
    logic        fault_w;

    assign fault_w = mem_resp_i.ack && mem_resp_i.error;

    // --------------------
    // Lane select
    // --------------------
    always_comb
    begin
        case (tag_i.addr[1:0])
            2'b11:   byte_sel_w = mem_resp_i.data_rd[31:24];
            2'b10:   byte_sel_w = mem_resp_i.data_rd[23:16];
            2'b01:   byte_sel_w = mem_resp_i.data_rd[15:8];
            default: byte_sel_w = mem_resp_i.data_rd[7:0];
        endcase
    end

    assign half_sel_w = tag_i.addr[1] ? mem_resp_i.data_rd[31:16] : mem_resp_i.data_rd[15:0];

    // --------------------
    // Writeback value
    // --------------------
    always_comb
    begin
        wb_o.value = '0;
        // Faulting address goes back as the value
        if (fault_w || unaligned_e2_i)
            wb_o.value = tag_i.addr;
        else if (mem_resp_i.ack && tag_i.load)
        begin
            if (tag_i.is_byte)
                wb_o.value = {{24{tag_i.is_signed & byte_sel_w[7]}}, byte_sel_w};
            else if (tag_i.half)
                wb_o.value = {{16{tag_i.is_signed & half_sel_w[15]}}, half_sel_w};
            else
                wb_o.value = mem_resp_i.data_rd;
        end
    end

    // Misalignment wins over a bus fault
    always_comb
    begin
        if (unaligned_e2_i && tag_i.load)
            wb_o.exception = EXC_MISALIGNED_LOAD;
        else if (unaligned_e2_i)
            wb_o.exception = EXC_MISALIGNED_STORE;
        else if (fault_w && tag_i.load)
            wb_o.exception = EXC_FAULT_LOAD;
        else if (fault_w)
            wb_o.exception = EXC_FAULT_STORE;
        else
            wb_o.exception = EXC_NONE;
    end

    assign wb_o.valid = mem_resp_i.ack || unaligned_e2_i;

endmodule

// ==== source/lsu_top.sv ====
// LSU top level connecting request stage, tag FIFO and response stage
module lsu_top
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  lsu_pkg::opcode_t   opcode_i,
    input  logic               mem_accept_i,
    input  lsu_pkg::mem_resp_t mem_resp_i,
    output lsu_pkg::mem_req_t  mem_req_o,
    output logic               stall_o,
    output lsu_pkg::wb_t       wb_o
);
    import lsu_pkg::*;

    logic     tag_push;
    logic     tag_pop;
    logic     unaligned_e2;
    lsu_tag_t tag_in;
    lsu_tag_t tag_out;

    // One pop per real or dummy completion
    assign tag_pop = mem_resp_i.ack || unaligned_e2;

    lsu_request u_request (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .opcode_i       (opcode_i),
        .mem_accept_i   (mem_accept_i),
        .mem_resp_i     (mem_resp_i),
        .mem_req_o      (mem_req_o),
        .stall_o        (stall_o),
        .tag_push_o     (tag_push),
        .tag_o          (tag_in),
        .unaligned_e2_o (unaligned_e2)
    );

    lsu_resp_fifo #(.DEPTH(TAG_DEPTH)) u_tags (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (tag_push),
        .pop_i  (tag_pop),
        .data_i (tag_in),
        .data_o (tag_out)
    );

    lsu_response u_response (
        .mem_resp_i     (mem_resp_i),
        .unaligned_e2_i (unaligned_e2),
        .tag_i          (tag_out),
        .wb_o           (wb_o)
    );

endmodule

// ==== test/tb_lsu.sv ====
// LSU testbench with clock, reset, bus memory model, LFSR, directed tests and watchdog
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int CLK_NS      = 40;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_OPS     = 64;
    localparam int CYC_PER_OP  = 16;
    localparam int TIMEOUT_NS  = (NUM_TESTS * MAX_OPS * CYC_PER_OP + 40) * CLK_NS;

    logic      clk_i;
    logic      rst_i;
    opcode_t   opcode_i;
    logic      mem_accept_i;
    mem_resp_t mem_resp_i;
    mem_req_t  mem_req_o;
    logic      stall_o;
    wb_t       wb_o;

    logic [7:0]  bus_mem [1024];
    logic [7:0]  ref_mem [1024];
    logic [31:0] lfsr_q;
    int          ack_cnt;
    mem_req_t    req_s;
    logic        acc_s;
    logic        acc_draw;
    int          delay_draw;

    // Completions as {value, exception} and transfers as {addr, rd, wr}
    logic [37:0] exp_wb [$];
    logic [37:0] got_wb [$];
    logic [36:0] exp_xfer [$];
    logic [36:0] got_xfer [$];
    logic        squash_next;
    int          errors;
    int          test_start_errs;
    int          tests_run;
    int          failed_tests;

    lsu_top dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .opcode_i     (opcode_i),
        .mem_accept_i (mem_accept_i),
        .mem_resp_i   (mem_resp_i),
        .mem_req_o    (mem_req_o),
        .stall_o      (stall_o),
        .wb_o         (wb_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic in_window(input logic [31:0] a);
        return a[9:6] == 4'hc;
    endfunction

    // --------------------
    // Bus model
    // --------------------
    always @(negedge clk_i)
    begin
        req_s = mem_req_o;
        acc_s = mem_accept_i;
        if (!rst_i)
        begin
            // Accept roughly three cycles out of four
            acc_draw = (rand_bits(2) != 0);
            if (wb_o.valid)
                got_wb.push_back({wb_o.value, wb_o.exception});
            if ((mem_req_o.rd || |mem_req_o.wr) && mem_accept_i)
            begin
                got_xfer.push_back({mem_req_o.addr, mem_req_o.rd, mem_req_o.wr});
                delay_draw = 1 + int'(rand_bits(2) % 3);
            end
            if ((ack_cnt != 0 || (mem_resp_i.ack && mem_resp_i.error)) &&
                (mem_req_o.rd || |mem_req_o.wr))
            begin
                $display("Bus request raised while an access is outstanding at %0t", $time);
                errors++;
            end
        end
    end

    always @(posedge clk_i)
    begin : bus_model
        int a;
        if (rst_i)
        begin
            mem_accept_i <= 1'b0;
            mem_resp_i   <= '0;
            ack_cnt      <= 0;
        end
        else
        begin
            mem_accept_i   <= acc_draw;
            mem_resp_i.ack <= 1'b0;
            if (ack_cnt != 0)
            begin
                if (ack_cnt == 1)
                    mem_resp_i.ack <= 1'b1;
                ack_cnt <= ack_cnt - 1;
            end
            if ((req_s.rd || |req_s.wr) && acc_s)
            begin
                a = {22'b0, req_s.addr[9:2], 2'b00};
                mem_resp_i.error   <= in_window(req_s.addr);
                mem_resp_i.data_rd <= {bus_mem[a + 3], bus_mem[a + 2], bus_mem[a + 1], bus_mem[a]};
                for (int k = 0; k < 4; k++)
                    if (req_s.wr[k] && !in_window(req_s.addr))
                        bus_mem[a + k] <= req_s.data_wr[8 * k +: 8];
                ack_cnt <= delay_draw;
            end
        end
    end

    // --------------------
    // Stimulus and checks
    // --------------------
    task automatic issue_op(input logic is_load, input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] imm, input logic [31:0] wdata);
        opcode_t     op;
        logic [31:0] ea;
        logic [1:0]  off;
        logic        mis;
        logic [3:0]  strb;
        logic [31:0] word;
        logic [31:0] lane;
        logic [31:0] val;
        int          a;
        ea   = base + {{20{imm[11]}}, imm};
        off  = ea[1:0];
        mis  = (f3[1:0] == 2'b10 && off != 2'b00) || (f3[1:0] == 2'b01 && off[0]);
        a    = {22'b0, ea[9:2], 2'b00};
        strb = (f3[1:0] == 2'b00) ? 4'b0001 << off :
               (f3[1:0] == 2'b01) ? 4'b0011 << off : 4'b1111;
        op.valid      = 1'b1;
        op.ra_operand = base;
        op.rb_operand = wdata;
        if (is_load)
            op.insn = {imm, 5'd1, f3, 5'd2, OPC_LOAD};
        else
            op.insn = {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE};
        // Reference model of the unit
        if (squash_next)
            squash_next = 1'b0;
        else if (mis)
        begin
            exp_wb.push_back({ea, is_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE});
            squash_next = 1'b1;
        end
        else
        begin
            exp_xfer.push_back({ea[31:2], 2'b00, is_load, is_load ? 4'b0000 : strb});
            if (in_window(ea))
            begin
                exp_wb.push_back({ea, is_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE});
                squash_next = 1'b1;
            end
            else if (is_load)
            begin
                word = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
                lane = word >> {off, 3'b000};
                case (f3)
                    F3_B:    val = {{24{lane[7]}}, lane[7:0]};
                    F3_BU:   val = {24'b0, lane[7:0]};
                    F3_H:    val = {{16{lane[15]}}, lane[15:0]};
                    F3_HU:   val = {16'b0, lane[15:0]};
                    default: val = word;
                endcase
                exp_wb.push_back({val, EXC_NONE});
            end
            else
            begin
                lane = wdata << {off, 3'b000};
                for (int k = 0; k < 4; k++)
                    if (strb[k])
                        ref_mem[a + k] = lane[8 * k +: 8];
                exp_wb.push_back({32'b0, EXC_NONE});
            end
        end
        opcode_i <= op;
        @(negedge clk_i);
        while (stall_o)
            @(negedge clk_i);
        @(posedge clk_i);
    endtask

    task automatic drain_and_check(input string name);
        int waited;
        opcode_i <= '0;
        waited = 0;
        while (got_wb.size() < exp_wb.size() && waited < 200)
        begin
            @(negedge clk_i);
            waited++;
        end
        // Room for any stray completion or request
        repeat (4) @(negedge clk_i);
        if (got_wb.size() != exp_wb.size() || got_xfer.size() != exp_xfer.size())
        begin
            $display("%s: got %0d completions and %0d transfers, expected %0d and %0d", name,
                     got_wb.size(), got_xfer.size(), exp_wb.size(), exp_xfer.size());
            errors++;
        end
        for (int i = 0; i < exp_wb.size() && i < got_wb.size(); i++)
        begin
            if (got_wb[i][37:6] != exp_wb[i][37:6])
            begin
                $display("MISMATCH wb_o.value got %h exp %h", got_wb[i][37:6], exp_wb[i][37:6]);
                errors++;
            end
            if (got_wb[i][5:0] != exp_wb[i][5:0])
            begin
                $display("MISMATCH wb_o.exception got %h exp %h", got_wb[i][5:0], exp_wb[i][5:0]);
                errors++;
            end
        end
        for (int i = 0; i < exp_xfer.size() && i < got_xfer.size(); i++)
        begin
            if (got_xfer[i] != exp_xfer[i])
            begin
                $display("MISMATCH mem_req_o {addr,rd,wr} got %h exp %h", got_xfer[i], exp_xfer[i]);
                errors++;
            end
        end
        exp_wb.delete();
        got_wb.delete();
        exp_xfer.delete();
        got_xfer.delete();
        squash_next = 1'b0;
        tests_run++;
        if (errors != test_start_errs)
            failed_tests++;
        $display("%s: %s", name, (errors == test_start_errs) ? "ok" : "failed");
        test_start_errs = errors;
        @(posedge clk_i);
    endtask

    task automatic word_store_load();
        issue_op(1'b0, F3_W, 32'h100, 12'h010, 32'hdeadbeef);
        issue_op(1'b1, F3_W, 32'h100, 12'h010, 32'h0);
        issue_op(1'b0, F3_W, 32'h140, 12'hfe0, 32'h13572468);
        issue_op(1'b1, F3_W, 32'h120, 12'h000, 32'h0);
        drain_and_check("word store and load");
    endtask

    task automatic sub_word_lanes();
        for (int off = 0; off < 4; off++)
            issue_op(1'b0, F3_B, 32'h200, 12'(off), 32'h80 | 32'(off * 8'h11));
        for (int off = 0; off < 4; off += 2)
            issue_op(1'b0, F3_H, 32'h210, 12'(off), 32'h8001 + 32'(off));
        for (int off = 0; off < 4; off++)
        begin
            issue_op(1'b1, F3_B, 32'h200, 12'(off), 32'h0);
            issue_op(1'b1, F3_BU, 32'h200, 12'(off), 32'h0);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            issue_op(1'b1, F3_H, 32'h210, 12'(off), 32'h0);
            issue_op(1'b1, F3_HU, 32'h210, 12'(off), 32'h0);
        end
        drain_and_check("byte and half lanes");
    endtask

    task automatic misaligned_access();
        // Each misaligned access is followed by a victim that gets squashed
        for (int off = 1; off < 4; off++)
        begin
            issue_op(1'b1, F3_W, 32'h80, 12'(off), 32'h0);
            issue_op(1'b1, F3_W, 32'h0, 12'h0, 32'h0);
            issue_op(1'b0, F3_W, 32'h90, 12'(off), 32'h55aa55aa);
            issue_op(1'b1, F3_W, 32'h0, 12'h0, 32'h0);
        end
        issue_op(1'b1, F3_H, 32'ha0, 12'h001, 32'h0);
        issue_op(1'b0, F3_W, 32'h0, 12'h0, 32'h0);
        issue_op(1'b0, F3_H, 32'ha0, 12'h003, 32'h1234);
        issue_op(1'b1, F3_HU, 32'ha4, 12'h001, 32'h0);
        drain_and_check("misaligned access");
    endtask

    task automatic fault_and_squash();
        issue_op(1'b1, F3_W, 32'h300, 12'h0, 32'h0);
        issue_op(1'b0, F3_W, 32'h40, 12'h0, 32'hbad0bad0);
        issue_op(1'b1, F3_W, 32'h40, 12'h0, 32'h0);
        issue_op(1'b0, F3_W, 32'h33c, 12'h0, 32'h11111111);
        issue_op(1'b1, F3_W, 32'h44, 12'h0, 32'h0);
        issue_op(1'b1, F3_B, 32'h301, 12'h0, 32'h0);
        issue_op(1'b1, F3_W, 32'h48, 12'h0, 32'h0);
        drain_and_check("bus fault and squash");
    endtask

    task automatic random_stream();
        logic        is_load;
        logic        use_unsigned;
        logic [1:0]  size;
        logic [2:0]  f3;
        logic [31:0] ea;
        logic [11:0] imm;
        for (int n = 0; n < 60; n++)
        begin
            is_load = 1'(rand_bits(1));
            size    = 2'(rand_bits(2) % 3);
            ea      = rand_bits(10);
            if (size == 2'd1)
                ea[0] = 1'b0;
            if (size == 2'd2)
                ea[1:0] = 2'b00;
            use_unsigned = 1'(rand_bits(1));
            f3  = {is_load & use_unsigned & (size != 2'd2), size};
            imm = 12'(rand_bits(12));
            issue_op(is_load, f3, ea - {{20{imm[11]}}, imm}, imm, rand_bits(32));
        end
        drain_and_check("random stream");
    endtask

    initial
    begin
        rst_i           = 1'b1;
        opcode_i        = '0;
        mem_accept_i    = 1'b0;
        mem_resp_i      = '0;
        ack_cnt         = 0;
        acc_draw        = 1'b0;
        delay_draw      = 1;
        lfsr_q          = 32'hc230b7b8;
        squash_next     = 1'b0;
        errors          = 0;
        test_start_errs = 0;
        tests_run       = 0;
        failed_tests    = 0;
        for (int i = 0; i < 1024; i++)
        begin
            bus_mem[i] = 8'((i * 37) ^ (i >> 8) ^ 8'h5a);
            ref_mem[i] = bus_mem[i];
        end
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        word_store_load();
        sub_word_lanes();
        misaligned_access();
        fault_and_squash();
        random_stream();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== list.f ====
source/lsu_pkg.sv
source/lsu_request.sv
source/lsu_resp_fifo.sv
source/lsu_response.sv
source/lsu_top.sv
test/tb_lsu.sv

// ==== Makefile ====
# Verilator simulation of the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
